/* Bender.yml */
package:
  name: dac_output_path

sources:
  # Shared package and link interface
  - common/dacPkg.sv
  - common/sampleIf.sv
  # Path blocks
  - formatter/dacSampleFormatter.sv
  - fifo/dacSampleFifo.sv
  - interleaver/dacIqInterleaver.sv
  # Top level
  - rtl/dacOutputTop.sv
  # Testbench
  - target: test
    files:
      - sim/dacOutputTb.sv

/* build.f */
common/dacPkg.sv
common/sampleIf.sv
formatter/dacSampleFormatter.sv
fifo/dacSampleFifo.sv
interleaver/dacIqInterleaver.sv
rtl/dacOutputTop.sv
sim/dacOutputTb.sv

/* common/dacPkg.sv */
// ##################################################
// Shared DAC path types: padded sample word, FIFO
// storage word and interleaver state encoding
// ##################################################

package dacPkg;

  // Widest DAC code the path supports
  // Narrower codes sit in the low bits, upper bits zero
  localparam int MaxDacWidth = 16;

  // One converted component in DAC code
  // Offset-binary style, sign kept and magnitude bits inverted
  typedef logic [MaxDacWidth-1:0] dacWord_t;

  // FIFO storage word
  // Q lives in the upper half, I in the lower half
  typedef logic [2*MaxDacWidth-1:0] fifoWord_t;

  // Interleaver phases
  // Idle waits for a pair
  // SendI launches the I word on the next edge
  // SendQ launches the Q word and may take the next pair
  typedef enum logic [1:0] {
    Idle  = 2'd0,
    SendI = 2'd1,
    SendQ = 2'd2
  } interleaveState_t;

endpackage

/* common/sampleIf.sv */
// ##################################################
// Valid/ready link carrying one converted I/Q pair
// ##################################################

`timescale 1ns/1ns

interface sampleIf;

  // Transfer on a rising edge with both Valid and Ready high
  logic Valid;
  logic Ready;

  // Converted components, zero-padded to the full word
  dacPkg::dacWord_t I;
  dacPkg::dacWord_t Q;

  // Producing side of the link
  // Holds Valid and data until the transfer
  modport source (
    output Valid,
    output I,
    output Q,
    input  Ready
  );

  // Consuming side of the link
  modport sink (
    input  Valid,
    input  I,
    input  Q,
    output Ready
  );

endinterface

/* fifo/dacSampleFifo.sv */
// ##################################################
// Synchronous first-word-fall-through FIFO holding
// converted I/Q pairs
// ##################################################

`timescale 1ns/1ns

module dacSampleFifo #(
  // Entry count, power of two
  parameter int FifoDepth = 16
) (
  input  logic    ADC_CLK_IN,
  input  logic    Reset,
  sampleIf.sink   in,
  sampleIf.source out
);

  localparam int AddrWidth = $clog2(FifoDepth);

  // Pair storage, Q high and I low
  dacPkg::fifoWord_t mem [FifoDepth];

  // Pointers carry one extra wrap bit
  logic [AddrWidth:0] wrPtr;
  logic [AddrWidth:0] rdPtr;

  logic full;
  logic empty;
  logic wrEn;
  logic rdEn;

  // Entry at the read pointer
  dacPkg::fifoWord_t headWord;

  // Same address with different wrap bits means full
  assign full  = (wrPtr[AddrWidth] != rdPtr[AddrWidth]) &&
                 (wrPtr[AddrWidth-1:0] == rdPtr[AddrWidth-1:0]);
  // Identical pointers mean empty
  assign empty = (wrPtr == rdPtr);

  // Ready toward the formatter drops only when full
  // A read in the same cycle does not free a slot for this write
  assign in.Ready = !full;
  assign wrEn     = in.Valid && !full;

  // Head entry is presented as soon as it is written
  assign out.Valid = !empty;
  assign rdEn      = out.Valid && out.Ready;

  // Asynchronous read of the head slot
  assign headWord = mem[rdPtr[AddrWidth-1:0]];
  assign out.I    = headWord[dacPkg::MaxDacWidth-1:0];
  assign out.Q    = headWord[2*dacPkg::MaxDacWidth-1:dacPkg::MaxDacWidth];

  // Storage write
  always_ff @(posedge ADC_CLK_IN) begin
    if (wrEn) begin
      mem[wrPtr[AddrWidth-1:0]] <= {in.Q, in.I};
    end
  end

  // Write pointer
  always_ff @(posedge ADC_CLK_IN or posedge Reset) begin
    if (Reset) begin
      wrPtr <= '0;
    end else if (wrEn) begin
      wrPtr <= wrPtr + 1'b1;
    end
  end

  // Read pointer advances on each handshake with the interleaver
  always_ff @(posedge ADC_CLK_IN or posedge Reset) begin
    if (Reset) begin
      rdPtr <= '0;
    end else if (rdEn) begin
      rdPtr <= rdPtr + 1'b1;
    end
  end

endmodule

/* formatter/dacSampleFormatter.sv */
// ##################################################
// Input register stage for DSP I/Q pairs with
// conversion from two's complement to DAC code
// ##################################################

`timescale 1ns/1ns

module dacSampleFormatter #(
  // DAC code width, 10, 14 or 16
  parameter int DacWidth = 10
) (
  input  logic                       ADC_CLK_IN,
  input  logic                       Reset,
  input  logic                       DspValid,
  output logic                       DspReady,
  input  logic signed [DacWidth-1:0] DspI,
  input  logic signed [DacWidth-1:0] DspQ,
  sampleIf.source                    out
);

  // Stage occupancy
  logic outValid;
  // Low while in reset and on the first edge after it
  logic running;
  // Registered converted pair
  dacPkg::dacWord_t iCode;
  dacPkg::dacWord_t qCode;
  // Handshake on the DSP side
  logic dspTake;

  // Keep the sign bit, invert the rest
  // Widening cast zero-pads the upper bits
  function automatic dacPkg::dacWord_t toDacCode(input logic signed [DacWidth-1:0] sample);
    logic [DacWidth-1:0] code;
    code = {sample[DacWidth-1], ~sample[DacWidth-2:0]};
    return dacPkg::dacWord_t'(code);
  endfunction

  // Stage can take a pair when empty or when it drains this cycle
  assign DspReady = running && (!outValid || out.Ready);
  assign dspTake  = DspValid && DspReady;

  // Control state
  always_ff @(posedge ADC_CLK_IN or posedge Reset) begin
    if (Reset) begin
      outValid <= 1'b0;
      running  <= 1'b0;
    end else begin
      running <= 1'b1;
      // Reload on an open stage, otherwise hold under back-pressure
      if (DspReady) begin
        outValid <= DspValid;
      end
    end
  end

  // Payload only moves on an accepted pair
  always_ff @(posedge ADC_CLK_IN) begin
    if (dspTake) begin
      iCode <= toDacCode(DspI);
      qCode <= toDacCode(DspQ);
    end
  end

  // Drive the link toward the FIFO
  assign out.Valid = outValid;
  assign out.I     = iCode;
  assign out.Q     = qCode;

endmodule

/* interleaver/dacIqInterleaver.sv */
// ##################################################
// I/Q interleaver driving the single DAC bus with
// select, write strobe and registered DAC reset
// ##################################################

`timescale 1ns/1ns

module dacIqInterleaver #(
  // DAC code width, 10, 14 or 16
  parameter int DacWidth = 10
) (
  input  logic                ADC_CLK_IN,
  input  logic                Reset,
  sampleIf.sink               in,
  output logic [DacWidth-1:0] DacData,
  output logic                DacIqSel,
  output logic                DacIqWrt,
  output logic                DacIqReset
);

  dacPkg::interleaveState_t state;

  // Captured pair waiting to go out
  dacPkg::dacWord_t pairI;
  dacPkg::dacWord_t pairQ;

  logic pairTake;

  // Open for a pair in Idle, or while Q goes out
  // Depends on state only, never on Valid
  assign in.Ready = (state == dacPkg::Idle) || (state == dacPkg::SendQ);
  assign pairTake = in.Valid && in.Ready;

  // Pair capture
  always_ff @(posedge ADC_CLK_IN) begin
    if (pairTake) begin
      pairI <= in.I;
      pairQ <= in.Q;
    end
  end

  // Phase sequencing and registered DAC bus
  always_ff @(posedge ADC_CLK_IN or posedge Reset) begin
    if (Reset) begin
      state    <= dacPkg::Idle;
      DacData  <= '0;
      DacIqSel <= 1'b0;
      DacIqWrt <= 1'b0;
    end else begin
      case (state)
        dacPkg::Idle: begin
          // Bus quiet, data holds its last word
          DacIqSel <= 1'b0;
          DacIqWrt <= 1'b0;
          if (in.Valid) begin
            state <= dacPkg::SendI;
          end
        end
        dacPkg::SendI: begin
          // I goes out with select high
          DacData  <= pairI[DacWidth-1:0];
          DacIqSel <= 1'b1;
          DacIqWrt <= 1'b1;
          state    <= dacPkg::SendQ;
        end
        dacPkg::SendQ: begin
          // Q goes out with select low
          DacData  <= pairQ[DacWidth-1:0];
          DacIqSel <= 1'b0;
          DacIqWrt <= 1'b1;
          // Chain straight into the next pair, no gap on the bus
          if (in.Valid) begin
            state <= dacPkg::SendI;
          end else begin
            state <= dacPkg::Idle;
          end
        end
        default: begin
          state    <= dacPkg::Idle;
          DacIqSel <= 1'b0;
          DacIqWrt <= 1'b0;
        end
      endcase
    end
  end

  // DAC reset follows Reset and clears on the first edge after release
  always_ff @(posedge ADC_CLK_IN or posedge Reset) begin
    if (Reset) begin
      DacIqReset <= 1'b1;
    end else begin
      DacIqReset <= 1'b0;
    end
  end

endmodule

/* rtl/dacOutputTop.sv */
// ##################################################
// DAC output path top: formatter, pair FIFO and
// I/Q interleaver on ADC_CLK_IN
// ##################################################

`timescale 1ns/1ns

module dacOutputTop #(
  // DAC code width, 10, 14 or 16
  parameter int DacWidth  = 10,
  // Pair FIFO entries, power of two
  parameter int FifoDepth = 16
) (
  input  logic                       ADC_CLK_IN,
  input  logic                       Reset,

  // Signed I/Q stream from the DSP
  input  logic                       DspValid,
  output logic                       DspReady,
  input  logic signed [DacWidth-1:0] DspI,
  input  logic signed [DacWidth-1:0] DspQ,

  // Interleaved DAC bus
  output logic [DacWidth-1:0]        DacData,
  output logic                       DacIqSel,
  output logic                       DacIqWrt,
  output logic                       DacIqReset
);

  // Formatter to FIFO
  sampleIf fmtIf ();
  // FIFO to interleaver
  sampleIf outIf ();

  // Register and convert incoming pairs
  dacSampleFormatter #(
    .DacWidth (DacWidth)
  ) formatter_i (
    .ADC_CLK_IN (ADC_CLK_IN),
    .Reset      (Reset),
    .DspValid   (DspValid),
    .DspReady   (DspReady),
    .DspI       (DspI),
    .DspQ       (DspQ),
    .out        (fmtIf.source)
  );

  // Absorb the rate gap between input and DAC bus
  dacSampleFifo #(
    .FifoDepth (FifoDepth)
  ) fifo_i (
    .ADC_CLK_IN (ADC_CLK_IN),
    .Reset      (Reset),
    .in         (fmtIf.sink),
    .out        (outIf.source)
  );

  // Two words per pair onto the DAC
  dacIqInterleaver #(
    .DacWidth (DacWidth)
  ) interleaver_i (
    .ADC_CLK_IN (ADC_CLK_IN),
    .Reset      (Reset),
    .in         (outIf.sink),
    .DacData    (DacData),
    .DacIqSel   (DacIqSel),
    .DacIqWrt   (DacIqWrt),
    .DacIqReset (DacIqReset)
  );

endmodule

/* sim/dacOutputTb.sv */
// ##################################################
// Random-stimulus testbench for the DAC output path
// with a pair model, checker task and watchdog
// ##################################################

`timescale 1ns/1ns

module dacOutputTb;

  localparam int DacWidth    = 10;
  localparam int FifoDepth   = 16;
  localparam int ClkPeriod   = 10;
  localparam int CornerPairs = 4;
  localparam int BurstPairs  = 200;
  localparam int RandomSteps = 300;
  // Four cycles per pair plus margin
  localparam int TimeoutCycles = (CornerPairs + BurstPairs + RandomSteps) * 4 + 2000;
  // Full FIFO plus the formatter and interleaver stages, two words each
  localparam int DrainCycles = 4 * (FifoDepth + 2);

  logic                       ADC_CLK_IN;
  logic                       Reset;
  logic                       DspValid;
  logic                       DspReady;
  logic signed [DacWidth-1:0] DspI;
  logic signed [DacWidth-1:0] DspQ;
  logic [DacWidth-1:0]        DacData;
  logic                       DacIqSel;
  logic                       DacIqWrt;
  logic                       DacIqReset;

  // Expected pairs in DAC code, Q high and I low
  logic [2*DacWidth-1:0] modelQ [$];
  int acceptedPairs = 0;
  int checkedPairs  = 0;
  // Set after an I word until its Q word shows up
  logic expectQ = 1'b0;
  logic sawBackPressure = 1'b0;
  logic [DacWidth-1:0] lastData = '0;
  int seedDummy;
  // Cycles spent waiting for the path to empty at the end
  int drainWait;

  dacOutputTop #(
    .DacWidth  (DacWidth),
    .FifoDepth (FifoDepth)
  ) dut_i (
    .ADC_CLK_IN (ADC_CLK_IN),
    .Reset      (Reset),
    .DspValid   (DspValid),
    .DspReady   (DspReady),
    .DspI       (DspI),
    .DspQ       (DspQ),
    .DacData    (DacData),
    .DacIqSel   (DacIqSel),
    .DacIqWrt   (DacIqWrt),
    .DacIqReset (DacIqReset)
  );

  initial ADC_CLK_IN = 1'b0;
  always #(ClkPeriod / 2) ADC_CLK_IN = ~ADC_CLK_IN;

  // Two's complement maps onto a descending code range
  // Most negative input gives the top code, most positive gives zero
  function automatic logic [DacWidth-1:0] expectedCode(input logic signed [DacWidth-1:0] sample);
    int level;
    level = ((1 << (DacWidth - 1)) - 1) - int'(sample);
    return level[DacWidth-1:0];
  endfunction

  task automatic stopOnError();
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkValue(input logic [31:0] expected, input logic [31:0] actual,
                            input string what);
    if (expected !== actual) begin
      $display("Mismatch at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
      stopOnError();
    end
  endtask

  // Present a pair and hold it until the DUT takes it
  // Valid stays high afterwards so pairs can go back to back
  task automatic sendPair(input logic signed [DacWidth-1:0] iVal,
                          input logic signed [DacWidth-1:0] qVal);
    DspValid = 1'b1;
    DspI     = iVal;
    DspQ     = qVal;
    @(negedge ADC_CLK_IN);
    while (!DspReady) begin
      @(negedge ADC_CLK_IN);
    end
    @(posedge ADC_CLK_IN);
    #1;
  endtask

  task automatic idleCycles(input int count);
    DspValid = 1'b0;
    repeat (count) begin
      @(posedge ADC_CLK_IN);
      #1;
    end
  endtask

  task automatic sendRandomPair();
    logic signed [DacWidth-1:0] iVal;
    logic signed [DacWidth-1:0] qVal;
    iVal = DacWidth'($urandom);
    qVal = DacWidth'($urandom);
    sendPair(iVal, qVal);
  endtask

  // Model update and DAC bus checks, sampled mid-cycle where all is stable
  always @(negedge ADC_CLK_IN) begin : busMonitor
    logic [2*DacWidth-1:0] head;
    dacPkg::interleaveState_t fsmState;
    if (!Reset) begin
      // Handshake seen now completes on the coming edge
      if (DspValid && DspReady) begin
        modelQ.push_back({expectedCode(DspQ), expectedCode(DspI)});
        acceptedPairs++;
      end
      if (DspValid && !DspReady) begin
        sawBackPressure = 1'b1;
      end
      if (expectQ) begin
        if (!(DacIqWrt && !DacIqSel)) begin
          fsmState = dut_i.interleaver_i.state;
          $display("Q word did not follow its I word at %0t ns, interleaver in %s",
                   $time, fsmState.name());
          stopOnError();
        end else begin
          head = modelQ.pop_front();
          checkValue(head[2*DacWidth-1:DacWidth], DacData, "Q word");
          checkedPairs++;
          expectQ = 1'b0;
        end
      end else if (DacIqWrt) begin
        if (!DacIqSel) begin
          $display("Q word written without a preceding I word at %0t ns", $time);
          stopOnError();
        end else if (modelQ.size() == 0) begin
          $display("DAC write at %0t ns with no pending pair", $time);
          stopOnError();
        end else begin
          checkValue(modelQ[0][DacWidth-1:0], DacData, "I word");
          expectQ = 1'b1;
        end
      end else begin
        // Quiet bus keeps the last word
        checkValue(0, DacIqSel, "DacIqSel while idle");
        checkValue(lastData, DacData, "DacData hold while idle");
      end
      lastData = DacData;
    end
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    stopOnError();
  end

  initial begin
    seedDummy = $urandom(12);
    Reset    = 1'b1;
    DspValid = 1'b0;
    DspI     = '0;
    DspQ     = '0;

    // Outputs quiet and DAC reset high while Reset holds
    repeat (8) begin
      @(negedge ADC_CLK_IN);
      checkValue(0, DacIqWrt, "DacIqWrt in reset");
      checkValue(0, DacIqSel, "DacIqSel in reset");
      checkValue(0, DacData, "DacData in reset");
      checkValue(0, DspReady, "DspReady in reset");
      checkValue(1, DacIqReset, "DacIqReset in reset");
    end
    @(posedge ADC_CLK_IN);
    #1;
    Reset = 1'b0;
    // Registered DAC reset lasts up to the next edge
    @(negedge ADC_CLK_IN);
    checkValue(1, DacIqReset, "DacIqReset before first edge");
    checkValue(0, DspReady, "DspReady before first edge");
    checkValue(0, DacIqWrt, "DacIqWrt after reset");
    @(negedge ADC_CLK_IN);
    checkValue(0, DacIqReset, "DacIqReset one cycle after reset");
    @(posedge ADC_CLK_IN);
    #1;

    // Corner codes first
    sendPair(-(1 << (DacWidth - 1)), (1 << (DacWidth - 1)) - 1);
    sendPair(-1, 0);
    sendPair(0, -1);
    sendPair((1 << (DacWidth - 1)) - 1, -(1 << (DacWidth - 1)));
    idleCycles(10);

    // Continuous burst, drains at half rate and fills the FIFO
    repeat (BurstPairs) begin
      sendRandomPair();
    end
    idleCycles(5);
    checkValue(1, sawBackPressure, "DspReady low during burst");

    // Random gaps between pairs
    repeat (RandomSteps) begin
      if (($urandom % 4) != 0) begin
        sendRandomPair();
      end else begin
        idleCycles(1 + ($urandom % 6));
      end
    end
    idleCycles(1);

    // Path empties within a bounded number of cycles
    drainWait = 0;
    while ((checkedPairs != acceptedPairs || expectQ) && drainWait < DrainCycles) begin
      @(posedge ADC_CLK_IN);
      drainWait++;
    end
    // Quiet stretch to catch stray writes
    idleCycles(20);
    if (modelQ.size() == 0 && !expectQ && checkedPairs == acceptedPairs) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("Pairs left unchecked: %0d accepted, %0d checked", acceptedPairs, checkedPairs);
      stopOnError();
    end
  end

endmodule
